// File: rtl/nnLayerPkg.sv
package nnLayerPkg;

	localparam int NUM_INPUTS = 10;
	localparam int NUM_NEURONS = 8;
	localparam int ACT_WIDTH = 8;
	localparam int ACC_WIDTH = 23; // Ten 16-bit products plus a 16-bit bias cannot overflow this
	localparam int FRAC_SHIFT = 6;
	localparam int ACT_MAX = 127;

	typedef logic signed [ACT_WIDTH-1:0] activation_t;

	typedef struct packed {
		logic valid;
		activation_t [NUM_INPUTS-1:0] act; // Activation 0 in the low byte
	} layerInput_t;

	typedef struct packed {
		logic valid;
		activation_t value;
	} neuronResult_t;

	// Trained weights, one row per neuron, one column per input activation
	localparam activation_t WEIGHTS [NUM_NEURONS][NUM_INPUTS] = '{
		'{8'sd31, 8'sd26, 8'sd22, 8'sd30, -8'sd7, 8'sd10, -8'sd22, -8'sd31, 8'sd2, 8'sd3},
		'{-8'sd12, 8'sd18, 8'sd5, -8'sd27, 8'sd14, 8'sd9, 8'sd21, -8'sd4, -8'sd16, 8'sd11},
		'{8'sd7, -8'sd3, 8'sd29, 8'sd12, 8'sd25, -8'sd19, 8'sd6, 8'sd13, -8'sd8, -8'sd20},
		'{-8'sd25, -8'sd14, 8'sd8, 8'sd4, -8'sd11, 8'sd30, 8'sd17, 8'sd9, 8'sd24, -8'sd6},
		'{8'sd19, 8'sd2, -8'sd15, 8'sd23, 8'sd6, 8'sd1, -8'sd28, 8'sd16, 8'sd10, 8'sd27},
		'{8'sd4, 8'sd33, -8'sd9, -8'sd18, 8'sd20, 8'sd15, 8'sd3, -8'sd24, 8'sd12, 8'sd8},
		'{-8'sd6, 8'sd11, 8'sd16, -8'sd2, -8'sd30, 8'sd24, 8'sd7, 8'sd19, -8'sd13, 8'sd14},
		'{8'sd28, -8'sd21, 8'sd1, 8'sd15, 8'sd9, -8'sd5, 8'sd26, 8'sd3, 8'sd18, -8'sd10}
	};

	// Biases are in the same fixed-point scale as the accumulated products
	localparam logic signed [15:0] BIASES [NUM_NEURONS] = '{
		16'sd512,
		-16'sd256,
		16'sd128,
		16'sd0,
		16'sd300,
		-16'sd100,
		16'sd64,
		16'sd700
	};

endpackage

// File: rtl/axiLitePkg.sv
package axiLitePkg;

	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;
	localparam int COUNT_WIDTH = 16; // Completed-vector count held in the status word

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Activation 4k+j sits in byte j of word k
	localparam logic [ADDR_WIDTH-1:0] ADDR_ACT0 = 8'h00;
	localparam logic [ADDR_WIDTH-1:0] ADDR_ACT1 = 8'h04;
	localparam logic [ADDR_WIDTH-1:0] ADDR_ACT2 = 8'h08;
	localparam logic [ADDR_WIDTH-1:0] ADDR_CTRL = 8'h0C; // Bit 0 starts a vector
	localparam logic [ADDR_WIDTH-1:0] ADDR_RES0 = 8'h10;
	localparam logic [ADDR_WIDTH-1:0] ADDR_RES1 = 8'h14;
	localparam logic [ADDR_WIDTH-1:0] ADDR_STATUS = 8'h18;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] awaddr;
		logic awvalid;
		logic [DATA_WIDTH-1:0] wdata;
		logic [STRB_WIDTH-1:0] wstrb;
		logic wvalid;
		logic bready;
	} axiWriteReq_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
	} axiWriteRsp_t;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] araddr;
		logic arvalid;
		logic rready;
	} axiReadReq_t;

	typedef struct packed {
		logic arready;
		logic [DATA_WIDTH-1:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axiReadRsp_t;

endpackage

// File: rtl/activationLoader.sv
module activationLoader
	import nnLayerPkg::*, axiLitePkg::*;
(
	input logic clk,
	input logic reset,
	input axiWriteReq_t writeReq,
	output axiWriteRsp_t writeRsp,
	output layerInput_t layerIn
);

	activation_t [NUM_INPUTS-1:0] actReg;
	logic launch;
	logic bvalid;
	logic [1:0] bresp;
	logic writeFire;
	logic actHit;
	logic ctrlHit;
	logic [1:0] wordIndex;
	logic startCmd;

	// Address and data are taken in the same cycle, and only with no response outstanding
	assign writeFire = writeReq.awvalid && writeReq.wvalid && !bvalid;

	always_comb
	begin
		actHit = 1'b0;
		ctrlHit = 1'b0;
		wordIndex = 2'd0;
		case (writeReq.awaddr)
			ADDR_ACT0:
			begin
				actHit = 1'b1;
				wordIndex = 2'd0;
			end
			ADDR_ACT1:
			begin
				actHit = 1'b1;
				wordIndex = 2'd1;
			end
			ADDR_ACT2:
			begin
				actHit = 1'b1;
				wordIndex = 2'd2;
			end
			ADDR_CTRL: ctrlHit = 1'b1;
			default: ;
		endcase
	end

	assign startCmd = ctrlHit && writeReq.wstrb[0] && writeReq.wdata[0];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			launch <= 1'b0;
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
		end
		else
		begin
			launch <= writeFire && startCmd; // One-cycle pulse after the handshake
			if (writeFire)
			begin
				bvalid <= 1'b1;
				bresp <= (actHit || ctrlHit) ? RESP_OKAY : RESP_SLVERR;
			end
			else if (writeReq.bready)
			begin
				bvalid <= 1'b0;
			end
			for (int i = 0; i < NUM_INPUTS; i++)
			begin
				// Bytes 2 and 3 of the last word have no activation behind them
				if (writeFire && actHit && wordIndex == 2'(i / STRB_WIDTH)
						&& writeReq.wstrb[i % STRB_WIDTH])
				begin
					actReg[i] <= writeReq.wdata[ACT_WIDTH * (i % STRB_WIDTH) +: ACT_WIDTH];
				end
			end
		end
	end

	assign writeRsp.awready = writeFire;
	assign writeRsp.wready = writeFire;
	assign writeRsp.bresp = bresp;
	assign writeRsp.bvalid = bvalid;

	assign layerIn.valid = launch;
	assign layerIn.act = actReg;

endmodule

// File: rtl/neuron.sv
module neuron
	import nnLayerPkg::*;
#(
	parameter int neuronIndex = 0
)
(
	input logic clk,
	input logic reset,
	input layerInput_t layerIn,
	output neuronResult_t result
);

	activation_t [NUM_INPUTS-1:0] actStage;
	logic signed [ACC_WIDTH-1:0] sumStage;
	activation_t outValue;
	logic validStage1;
	logic validStage2;
	logic resultValid;
	logic signed [ACC_WIDTH-1:0] weightedSum;
	logic [ACC_WIDTH-1:0] rounded;
	activation_t rectified;

	always_comb
	begin
		weightedSum = BIASES[neuronIndex]; // Sign-extended to the accumulator width
		for (int i = 0; i < NUM_INPUTS; i++)
		begin
			weightedSum = weightedSum + actStage[i] * WEIGHTS[neuronIndex][i];
		end
	end

	// Round half up on the first bit shifted out, then clamp or clip to zero
	always_comb
	begin
		rounded = (sumStage >>> FRAC_SHIFT) + sumStage[FRAC_SHIFT-1];
		if (sumStage[ACC_WIDTH-1])
			rectified = '0;
		else if (rounded > ACT_MAX)
			rectified = ACT_WIDTH'(ACT_MAX);
		else
			rectified = rounded[ACT_WIDTH-1:0];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validStage1 <= 1'b0;
			validStage2 <= 1'b0;
			resultValid <= 1'b0;
		end
		else
		begin
			validStage1 <= layerIn.valid;
			validStage2 <= validStage1;
			resultValid <= validStage2;
		end
	end

	// The datapath runs every cycle and is qualified only by the valid chain
	always_ff @(posedge clk)
	begin
		actStage <= layerIn.act;
		sumStage <= weightedSum;
		outValue <= rectified;
	end

	assign result.valid = resultValid;
	assign result.value = outValue;

endmodule

// File: rtl/resultCollector.sv
module resultCollector
	import nnLayerPkg::*, axiLitePkg::*;
(
	input logic clk,
	input logic reset,
	input neuronResult_t results [NUM_NEURONS],
	input axiReadReq_t readReq,
	output axiReadRsp_t readRsp
);

	activation_t resultReg [NUM_NEURONS];
	logic [COUNT_WIDTH-1:0] doneCount;
	logic rvalid;
	logic [DATA_WIDTH-1:0] rdata;
	logic [1:0] rresp;
	logic readFire;
	logic [DATA_WIDTH-1:0] readData;
	logic [1:0] readResp;

	assign readFire = readReq.arvalid && !rvalid;

	// All neurons share one pipeline, so neuron 0 speaks for the whole layer
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			doneCount <= '0;
			for (int n = 0; n < NUM_NEURONS; n++)
			begin
				resultReg[n] <= '0;
			end
		end
		else if (results[0].valid)
		begin
			doneCount <= doneCount + 1'b1; // Wraps at 16 bits
			for (int n = 0; n < NUM_NEURONS; n++)
			begin
				resultReg[n] <= results[n].value;
			end
		end
	end

	always_comb
	begin
		readData = '0;
		readResp = RESP_OKAY;
		case (readReq.araddr)
			ADDR_ACT0, ADDR_ACT1, ADDR_ACT2, ADDR_CTRL: ; // Write-side registers read as zero
			ADDR_RES0:
			begin
				for (int j = 0; j < STRB_WIDTH; j++)
				begin
					readData[ACT_WIDTH * j +: ACT_WIDTH] = resultReg[j];
				end
			end
			ADDR_RES1:
			begin
				for (int j = 0; j < STRB_WIDTH; j++)
				begin
					readData[ACT_WIDTH * j +: ACT_WIDTH] = resultReg[STRB_WIDTH + j];
				end
			end
			ADDR_STATUS: readData[COUNT_WIDTH-1:0] = doneCount;
			default: readResp = RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rvalid <= 1'b0;
			rdata <= '0;
			rresp <= RESP_OKAY;
		end
		else if (readFire)
		begin
			rvalid <= 1'b1;
			rdata <= readData; // Held until the host takes it
			rresp <= readResp;
		end
		else if (readReq.rready)
		begin
			rvalid <= 1'b0;
		end
	end

	assign readRsp.arready = readFire;
	assign readRsp.rdata = rdata;
	assign readRsp.rresp = rresp;
	assign readRsp.rvalid = rvalid;

endmodule

// File: rtl/denseLayerTop.sv
module denseLayerTop
	import nnLayerPkg::*, axiLitePkg::*;
(
	input logic clk,
	input logic reset,
	input axiWriteReq_t writeReq,
	output axiWriteRsp_t writeRsp,
	input axiReadReq_t readReq,
	output axiReadRsp_t readRsp
);

	layerInput_t layerIn;
	neuronResult_t results [NUM_NEURONS];

	activationLoader loader (
		.clk(clk),
		.reset(reset),
		.writeReq(writeReq),
		.writeRsp(writeRsp),
		.layerIn(layerIn)
	);

	// Every neuron sees the same vector and picks its own weight row
	for (genvar n = 0; n < NUM_NEURONS; n++)
	begin : gNeuron
		neuron #(
			.neuronIndex(n)
		) neuronInst (
			.clk(clk),
			.reset(reset),
			.layerIn(layerIn),
			.result(results[n])
		);
	end

	resultCollector collector (
		.clk(clk),
		.reset(reset),
		.results(results),
		.readReq(readReq),
		.readRsp(readRsp)
	);

endmodule

// File: testbench/denseLayer_sva.sv
module denseLayerSva
	import nnLayerPkg::*, axiLitePkg::*;
(
	input logic clk,
	input logic reset,
	input axiWriteReq_t writeReq,
	input axiWriteRsp_t writeRsp,
	input axiReadReq_t readReq,
	input axiReadRsp_t readRsp,
	input layerInput_t layerIn,
	input neuronResult_t results [NUM_NEURONS]
);

	bHeld: assert property (@(posedge clk) disable iff (reset)
		writeRsp.bvalid && !writeReq.bready |=> writeRsp.bvalid && $stable(writeRsp.bresp))
		else $error("Write response dropped or changed before bready");

	rHeld: assert property (@(posedge clk) disable iff (reset)
		readRsp.rvalid && !readReq.rready
			|=> readRsp.rvalid && $stable(readRsp.rdata) && $stable(readRsp.rresp))
		else $error("Read response dropped or changed before rready");

	noWriteWhilePending: assert property (@(posedge clk) disable iff (reset)
		writeRsp.bvalid |-> !writeRsp.awready)
		else $error("Write accepted while a write response was pending");

	for (genvar n = 0; n < NUM_NEURONS; n++)
	begin : gLatency
		launchToResult: assert property (@(posedge clk) disable iff (reset)
			layerIn.valid |-> ##3 results[n].valid)
			else $error("Neuron %0d missed its result 3 cycles after launch", n);

		resultFromLaunch: assert property (@(posedge clk) disable iff (reset)
			results[n].valid |-> $past(layerIn.valid, 3))
			else $error("Neuron %0d produced a result with no launch 3 cycles before", n);
	end

endmodule

bind denseLayerTop denseLayerSva sva (
	.clk(clk),
	.reset(reset),
	.writeReq(writeReq),
	.writeRsp(writeRsp),
	.readReq(readReq),
	.readRsp(readRsp),
	.layerIn(layerIn),
	.results(results)
);

// File: testbench/denseLayerTb.sv
module denseLayerTb
	import nnLayerPkg::*, axiLitePkg::*;
();

	localparam int TIMEOUT_CYCLES = 50;
	localparam int RANDOM_VECTORS = 50;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] data;
		logic [1:0] resp;
	} readRecord_t;

	logic clk;
	logic reset;
	axiWriteReq_t writeReq;
	axiWriteRsp_t writeRsp;
	axiReadReq_t readReq;
	axiReadRsp_t readRsp;

	int seed = 32'h5ca9_6486;
	int errorCount = 0;
	int stallCount = 0;
	int compareCount = 0;
	int startCount = 0;
	activation_t [NUM_INPUTS-1:0] actModel; // What the activation registers should hold
	readRecord_t observedQ [$];
	readRecord_t expectedQ [$];

	denseLayerTop DUT (
		.clk(clk),
		.reset(reset),
		.writeReq(writeReq),
		.writeRsp(writeRsp),
		.readReq(readReq),
		.readRsp(readRsp)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Weighted sum plus bias, rectified, rounded half up on 1/64 steps and clamped
	function automatic logic [63:0] expectedOutputs(input activation_t [NUM_INPUTS-1:0] acts);
		logic [63:0] expected;
		int sum;
		int scaled;
		expected = '0;
		for (int n = 0; n < NUM_NEURONS; n++)
		begin
			sum = BIASES[n];
			for (int i = 0; i < NUM_INPUTS; i++)
				sum += int'(acts[i]) * int'(WEIGHTS[n][i]);
			if (sum < 0)
				scaled = 0;
			else
				scaled = sum / 64 + ((sum % 64 >= 32) ? 1 : 0);
			if (scaled > ACT_MAX)
				scaled = ACT_MAX;
			expected[8 * n +: 8] = scaled[7:0];
		end
		return expected;
	endfunction

	function automatic int readyDelay();
		int rnd;
		rnd = $random(seed);
		return rnd & 3;
	endfunction

	task automatic finishRun();
		$display("Run complete with %0d mismatches, %0d timeouts and %0d reads compared",
			errorCount, stallCount, compareCount);
		if (errorCount == 0 && stallCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	task automatic reportStall(input string what);
		stallCount++;
		$display("Timeout at %0t because the %s", $time, what);
		finishRun();
	endtask

	task automatic axiWrite(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data,
			input logic [STRB_WIDTH-1:0] strb, output logic [1:0] resp);
		int waited;
		int delay;
		delay = readyDelay();
		waited = 0;
		@(posedge clk);
		writeReq.awaddr <= addr;
		writeReq.wdata <= data;
		writeReq.wstrb <= strb;
		writeReq.awvalid <= 1'b1;
		writeReq.wvalid <= 1'b1;
		@(negedge clk);
		while (!(writeRsp.awready && writeRsp.wready) && waited < TIMEOUT_CYCLES)
		begin
			waited++;
			@(negedge clk);
		end
		if (!(writeRsp.awready && writeRsp.wready))
			reportStall("write address and data were never accepted");
		@(posedge clk);
		writeReq.awvalid <= 1'b0;
		writeReq.wvalid <= 1'b0;
		repeat (delay) @(posedge clk); // B must wait for us
		writeReq.bready <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (!writeRsp.bvalid && waited < TIMEOUT_CYCLES)
		begin
			waited++;
			@(negedge clk);
		end
		if (!writeRsp.bvalid)
			reportStall("write response never arrived");
		resp = writeRsp.bresp;
		@(posedge clk);
		writeReq.bready <= 1'b0;
	endtask

	task automatic axiRead(input logic [ADDR_WIDTH-1:0] addr, output logic [DATA_WIDTH-1:0] data,
			output logic [1:0] resp);
		int waited;
		int delay;
		delay = readyDelay();
		waited = 0;
		@(posedge clk);
		readReq.araddr <= addr;
		readReq.arvalid <= 1'b1;
		@(negedge clk);
		while (!readRsp.arready && waited < TIMEOUT_CYCLES)
		begin
			waited++;
			@(negedge clk);
		end
		if (!readRsp.arready)
			reportStall("read address was never accepted");
		@(posedge clk);
		readReq.arvalid <= 1'b0;
		repeat (delay) @(posedge clk);
		readReq.rready <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (!readRsp.rvalid && waited < TIMEOUT_CYCLES)
		begin
			waited++;
			@(negedge clk);
		end
		if (!readRsp.rvalid)
			reportStall("read data never arrived");
		data = readRsp.rdata;
		resp = readRsp.rresp;
		@(posedge clk);
		readReq.rready <= 1'b0;
	endtask

	task automatic expectWrite(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data,
			input logic [STRB_WIDTH-1:0] strb, input logic [1:0] expResp);
		logic [1:0] resp;
		axiWrite(addr, data, strb, resp);
		if (resp !== expResp)
		begin
			errorCount++;
			$display("MISMATCH at %0t: write to %h answered %0d, expected %0d",
				$time, addr, resp, expResp);
		end
	endtask

	task automatic expectRead(input logic [ADDR_WIDTH-1:0] addr,
			input logic [DATA_WIDTH-1:0] expData, input logic [1:0] expResp);
		logic [DATA_WIDTH-1:0] data;
		logic [1:0] resp;
		axiRead(addr, data, resp);
		observedQ.push_back('{addr, data, resp});
		expectedQ.push_back('{addr, expData, expResp});
	endtask

	task automatic writeActWord(input int word, input logic [31:0] data, input logic [3:0] strb);
		expectWrite(ADDR_ACT0 + 8'(4 * word), data, strb, RESP_OKAY);
		for (int j = 0; j < STRB_WIDTH; j++)
			if (strb[j] && 4 * word + j < NUM_INPUTS)
				actModel[4 * word + j] = data[8 * j +: 8];
	endtask

	task automatic loadVector(input activation_t [NUM_INPUTS-1:0] acts);
		writeActWord(0, acts[3:0], 4'hF);
		writeActWord(1, acts[7:4], 4'hF);
		writeActWord(2, {16'h0, acts[9:8]}, 4'h3);
	endtask

	task automatic checkResults();
		logic [63:0] expected;
		expected = expectedOutputs(actModel);
		expectRead(ADDR_RES0, expected[31:0], RESP_OKAY);
		expectRead(ADDR_RES1, expected[63:32], RESP_OKAY);
		expectRead(ADDR_STATUS, {16'h0, 16'(startCount)}, RESP_OKAY);
	endtask

	task automatic startAndCheck();
		logic [DATA_WIDTH-1:0] data;
		logic [1:0] resp;
		int polls;
		polls = 0;
		expectWrite(ADDR_CTRL, 32'h1, 4'h1, RESP_OKAY);
		startCount++;
		axiRead(ADDR_STATUS, data, resp);
		while (data[15:0] != 16'(startCount) && polls < TIMEOUT_CYCLES)
		begin
			polls++;
			axiRead(ADDR_STATUS, data, resp);
		end
		if (data[15:0] != 16'(startCount))
			reportStall("completed-vector count never reached the number of starts");
		checkResults();
	endtask

	always @(negedge clk)
	begin : compareReads
		readRecord_t seen;
		readRecord_t want;
		while (observedQ.size() > 0 && expectedQ.size() > 0)
		begin
			seen = observedQ.pop_front();
			want = expectedQ.pop_front();
			compareCount++;
			if (seen !== want)
			begin
				errorCount++;
				$display("MISMATCH at %0t: read of %h gave %h resp %0d, expected %h resp %0d",
					$time, seen.addr, seen.data, seen.resp, want.data, want.resp);
			end
		end
	end

	initial
	begin : stimulus
		activation_t [NUM_INPUTS-1:0] acts;
		int rnd;
		writeReq = '0;
		readReq = '0;
		reset = 1'b1;
		actModel = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		expectRead(ADDR_RES0, '0, RESP_OKAY);
		expectRead(ADDR_RES1, '0, RESP_OKAY);
		expectRead(ADDR_STATUS, '0, RESP_OKAY);

		loadVector('0); // Bias only
		startAndCheck();
		loadVector({NUM_INPUTS{8'h7F}});
		startAndCheck();
		loadVector({NUM_INPUTS{8'h81}});
		startAndCheck();
		acts = '0;
		acts[3] = 8'sd7; // Neuron 3 sums to 28, just under half a step
		loadVector(acts);
		startAndCheck();
		acts[3] = 8'sd8;
		loadVector(acts);
		startAndCheck();

		for (int v = 0; v < RANDOM_VECTORS; v++)
		begin
			for (int i = 0; i < NUM_INPUTS; i++)
			begin
				rnd = $random(seed);
				acts[i] = rnd[7:0];
			end
			loadVector(acts);
			startAndCheck();
		end

		rnd = $random(seed);
		writeActWord(1, rnd, 4'b0100);
		rnd = $random(seed);
		writeActWord(0, rnd, 4'b1001);
		rnd = $random(seed);
		writeActWord(2, rnd, 4'b1110);
		startAndCheck();

		expectWrite(ADDR_RES0, 32'hFFFF_FFFF, 4'hF, RESP_SLVERR);
		expectWrite(ADDR_STATUS, 32'h1, 4'hF, RESP_SLVERR);
		expectWrite(8'h40, 32'h1, 4'hF, RESP_SLVERR);
		expectWrite(ADDR_CTRL, 32'h1, 4'h2, RESP_OKAY); // Byte 0 not strobed so nothing starts
		expectRead(8'h1C, '0, RESP_SLVERR);
		expectRead(8'hF0, '0, RESP_SLVERR);
		expectRead(ADDR_ACT1, '0, RESP_OKAY);
		repeat (8) @(posedge clk);
		checkResults();
		repeat (2) @(posedge clk);
		finishRun();
	end

endmodule

// File: verilog.f
rtl/nnLayerPkg.sv
rtl/axiLitePkg.sv
rtl/activationLoader.sv
rtl/neuron.sv
rtl/resultCollector.sv
rtl/denseLayerTop.sv
testbench/denseLayer_sva.sv
testbench/denseLayerTb.sv

// File: Bender.yml
package:
  name: dense_layer

sources:
  - rtl/nnLayerPkg.sv
  - rtl/axiLitePkg.sv
  - rtl/activationLoader.sv
  - rtl/neuron.sv
  - rtl/resultCollector.sv
  - rtl/denseLayerTop.sv
  - target: simulation
    files:
      - testbench/denseLayer_sva.sv
      - testbench/denseLayerTb.sv
